// File: Makefile
# Verilator build and run of the ball physics testbench

VERILATOR ?= verilator
TOP       ?= ballPhysicsTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: hw/ballPhysicsTop.sv
`timescale 1ns/1ps

module ballPhysicsTop (
	input  logic               clk,
	input  logic               resetN,
	input  logic               frameTick,
	input  logic               pause,
	input  logic               levelReset,
	input  ballPkg::collisionT collision,
	input  ballPkg::speedT     flipperSpeedX,
	input  ballPkg::speedT     springSpeedY,
	output ballPkg::pixelT     topLeftX,
	output ballPkg::pixelT     topLeftY
);

	ballPkg::axisEventsT eventsX;
	ballPkg::axisEventsT eventsY;
	ballPkg::speedT      speedX;
	ballPkg::speedT      speedY;

	// Decode, pulses to per-axis events
	collisionDecoder collisionDecoder_inst (
		.collision (collision),
		.eventsX   (eventsX),
		.eventsY   (eventsY)
	);

	// Execute, speed registers
	velocityUnit velocityUnit_inst (
		.clk           (clk),
		.resetN        (resetN),
		.frameTick     (frameTick),
		.pause         (pause),
		.levelReset    (levelReset),
		.eventsX       (eventsX),
		.eventsY       (eventsY),
		.flipperSpeedX (flipperSpeedX),
		.springSpeedY  (springSpeedY),
		.speedX        (speedX),
		.speedY        (speedY)
	);

	// Result, position and pixel output
	positionIntegrator positionIntegrator_inst (
		.clk        (clk),
		.resetN     (resetN),
		.frameTick  (frameTick),
		.pause      (pause),
		.levelReset (levelReset),
		.speedX     (speedX),
		.speedY     (speedY),
		.topLeftX   (topLeftX),
		.topLeftY   (topLeftY)
	);

endmodule

// File: hw/ballPhysics_defines.svh
`ifndef BALL_PHYSICS_DEFINES_SVH
`define BALL_PHYSICS_DEFINES_SVH

// Start position of the ball, top left corner in screen pixels
`define BALL_INITIAL_X 300
`define BALL_INITIAL_Y 60

// Subpixel units per screen pixel
`define FIXED_POINT_MULTIPLIER 64

// Added to Y speed once per frame, in subpixel units per frame
`define GRAVITY 6

// Positive Y points down the screen, so a positive speed means falling
// and a negative speed means rising

`endif

// File: hw/ballPkg.sv
package ballPkg;

	typedef logic signed [31:0] speedT;    // Subpixels per frame
	typedef logic signed [31:0] posFixedT; // Subpixels
	typedef logic signed [10:0] pixelT;

	// One bit per side of the ball's bounding box
	// bit 0 bottom, bit 1 right, bit 2 top, bit 3 left
	typedef logic [3:0] edgeCodeT;

	// Single-cycle pulses from the rendering side
	typedef struct packed {
		logic     borderTop;
		logic     borderLeft;
		logic     borderRight;
		logic     flipper;
		logic     obstacle;
		logic     springPulse;
		logic     bumperPulse;
		logic     frame;
		edgeCodeT hitEdge;
	} collisionT;

	// Candidate velocity events for one axis, highest priority first
	typedef struct packed {
		logic reflectIfNeg;        // Reverse while own speed < 0
		logic reflectIfPos;        // Reverse while own speed > 0
		logic addImpulseIfFalling; // Add flipper speed while Y > 0
		logic copyYIfRising;       // Take Y speed while Y < 0
		logic springBoost;         // Add spring speed when it is negative
		logic springReflect;       // Reverse when spring speed is not negative
	} axisEventsT;

endpackage

// File: hw/collisionDecoder.sv
`timescale 1ns/1ps

module collisionDecoder (
	input  ballPkg::collisionT  collision,
	output ballPkg::axisEventsT eventsX,
	output ballPkg::axisEventsT eventsY
);

	logic edgeBottom;
	logic edgeRight;
	logic edgeTop;
	logic edgeLeft;

	logic hitLeft;   // Anything that blocks the ball on its left side
	logic hitRight;
	logic hitTop;
	logic hitBottom;
	logic springHit;
	logic bumperHit;

	assign edgeBottom = collision.hitEdge[0];
	assign edgeRight  = collision.hitEdge[1];
	assign edgeTop    = collision.hitEdge[2];
	assign edgeLeft   = collision.hitEdge[3];

	// Borders, obstacles and the playfield frame act alike per side
	assign hitLeft = collision.borderLeft
		| (collision.obstacle & edgeLeft)
		| (collision.frame & edgeLeft);

	assign hitRight = collision.borderRight
		| (collision.obstacle & edgeRight)
		| (collision.frame & edgeRight);

	assign hitTop = collision.borderTop | (collision.obstacle & edgeTop);

	// The flipper always sits below the ball
	assign hitBottom = collision.flipper | (collision.obstacle & edgeBottom);

	// Spring only counts when it hits from below
	assign springHit = collision.springPulse & edgeBottom;

	// A spring hit always wins over the bumper on Y, so the bumper
	// can share the rising reflection once the spring is masked out
	assign bumperHit = collision.bumperPulse & ~springHit;

	always_comb begin
		eventsX = '0;

		eventsX.reflectIfNeg        = hitLeft;    // Moving left
		eventsX.reflectIfPos        = hitRight;   // Moving right
		eventsX.addImpulseIfFalling = collision.flipper;
		eventsX.copyYIfRising       = collision.bumperPulse;
	end

	always_comb begin
		eventsY = '0;

		eventsY.reflectIfNeg  = hitTop | bumperHit; // Rising
		eventsY.reflectIfPos  = hitBottom;          // Falling
		eventsY.springBoost   = springHit;
		eventsY.springReflect = springHit;
	end

endmodule

// File: hw/positionIntegrator.sv
`timescale 1ns/1ps
`include "ballPhysics_defines.svh"

module positionIntegrator (
	input  logic           clk,
	input  logic           resetN,
	input  logic           frameTick,
	input  logic           pause,
	input  logic           levelReset,
	input  ballPkg::speedT speedX,
	input  ballPkg::speedT speedY,
	output ballPkg::pixelT topLeftX,
	output ballPkg::pixelT topLeftY
);

	localparam ballPkg::posFixedT initPosX = `BALL_INITIAL_X * `FIXED_POINT_MULTIPLIER;
	localparam ballPkg::posFixedT initPosY = `BALL_INITIAL_Y * `FIXED_POINT_MULTIPLIER;

	ballPkg::posFixedT posX;
	ballPkg::posFixedT posY;
	ballPkg::posFixedT pixelX; // Still full width, before narrowing
	ballPkg::posFixedT pixelY;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= initPosX;
			posY <= initPosY;
		end
		else if (levelReset) begin
			posX <= initPosX;
			posY <= initPosY;
		end
		else if (!pause && frameTick) begin
			// Speeds seen here are the ones from before this tick
			posX <= posX + speedX;
			posY <= posY + speedY;
		end
	end

	// Signed division rounds toward zero
	assign pixelX = posX / `FIXED_POINT_MULTIPLIER;
	assign pixelY = posY / `FIXED_POINT_MULTIPLIER;

	assign topLeftX = ballPkg::pixelT'(pixelX);
	assign topLeftY = ballPkg::pixelT'(pixelY);

endmodule

// File: hw/velocityUnit.sv
`timescale 1ns/1ps
`include "ballPhysics_defines.svh"

module velocityUnit (
	input  logic                clk,
	input  logic                resetN,
	input  logic                frameTick,
	input  logic                pause,
	input  logic                levelReset,
	input  ballPkg::axisEventsT eventsX,
	input  ballPkg::axisEventsT eventsY,
	input  ballPkg::speedT      flipperSpeedX,
	input  ballPkg::speedT      springSpeedY,
	output ballPkg::speedT      speedX,
	output ballPkg::speedT      speedY
);

	ballPkg::speedT nextSpeedX;
	ballPkg::speedT nextSpeedY;

	// First eligible event on one axis, the same rules serve both axes.
	// The sign tests on Y always look at the Y speed held in the register
	function automatic ballPkg::speedT applyEvents(
		input ballPkg::axisEventsT ev,
		input ballPkg::speedT      cur,
		input ballPkg::speedT      ySpeed,
		input ballPkg::speedT      impulse,
		input ballPkg::speedT      spring
	);
		ballPkg::speedT result;
		logic           movingNeg;
		logic           movingPos;
		logic           falling;
		logic           rising;

		movingNeg = (cur < 0);
		movingPos = (cur > 0);
		falling   = (ySpeed > 0);
		rising    = (ySpeed < 0);
		result    = cur;

		if ((ev.reflectIfNeg && movingNeg) || (ev.reflectIfPos && movingPos)) begin
			result = -cur;
		end
		else if (ev.addImpulseIfFalling && falling) begin
			result = cur + impulse;
		end
		else if (ev.copyYIfRising && rising) begin
			result = ySpeed;
		end
		else if (ev.springBoost && (spring < 0)) begin
			result = cur + spring; // Spring pushes upward
		end
		else if (ev.springReflect && (spring >= 0)) begin
			result = -cur;
		end

		return result;
	endfunction

	assign nextSpeedX = applyEvents(eventsX, speedX, speedY, flipperSpeedX, springSpeedY);
	assign nextSpeedY = applyEvents(eventsY, speedY, speedY, flipperSpeedX, springSpeedY);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedX <= '0;
			speedY <= '0;
		end
		else if (levelReset) begin
			speedX <= '0;
			speedY <= '0;
		end
		else if (!pause) begin
			if (frameTick) begin
				speedY <= speedY + `GRAVITY; // Pulses in this cycle are dropped
			end
			else begin
				speedX <= nextSpeedX;
				speedY <= nextSpeedY;
			end
		end
	end

endmodule

// File: sim.f
+incdir+hw
hw/ballPkg.sv
hw/collisionDecoder.sv
hw/velocityUnit.sv
hw/positionIntegrator.sv
hw/ballPhysicsTop.sv
sim/ballPhysicsChecker.sv
sim/ballPhysicsTb.sv

// File: sim/ballPhysicsChecker.sv
`timescale 1ns/1ps
`include "ballPhysics_defines.svh"

module ballPhysicsChecker (
	input  logic               clk,
	input  logic               resetN,
	input  logic               frameTick,
	input  logic               pause,
	input  logic               levelReset,
	input  ballPkg::collisionT collision,
	input  ballPkg::speedT     flipperSpeedX,
	input  ballPkg::speedT     springSpeedY,
	input  ballPkg::pixelT     topLeftX,
	input  ballPkg::pixelT     topLeftY,
	input  int                 testNum,
	input  logic               testEnd,
	output int                 testsRun,
	output int                 testsFailed,
	output int                 errorCount
);

	ballPkg::posFixedT modelPosX;
	ballPkg::posFixedT modelPosY;
	ballPkg::speedT    modelSpeedX;
	ballPkg::speedT    modelSpeedY;
	logic              checkPending;
	int                mismatches = 0;
	int                mismatchesAtStart = 0;
	int                runCount = 0;
	int                failCount = 0;

	assign testsRun    = runCount;
	assign testsFailed = failCount;
	assign errorCount  = mismatches;

	// Truncates toward zero, then wraps into the pixel width
	function automatic ballPkg::pixelT toPixel(input ballPkg::posFixedT pos);
		return ballPkg::pixelT'(pos / `FIXED_POINT_MULTIPLIER);
	endfunction

	task automatic restartBall();
		modelPosX   = `BALL_INITIAL_X * `FIXED_POINT_MULTIPLIER;
		modelPosY   = `BALL_INITIAL_Y * `FIXED_POINT_MULTIPLIER;
		modelSpeedX = '0;
		modelSpeedY = '0;
	endtask

	// Both axes look only at the speeds from before the pulse
	task automatic applyCollision();
		ballPkg::speedT oldX;
		ballPkg::speedT oldY;
		logic           leftSide;
		logic           rightSide;
		logic           topSide;
		logic           bottomSide;
		logic           springHit;

		oldX       = modelSpeedX;
		oldY       = modelSpeedY;
		leftSide   = collision.borderLeft | ((collision.obstacle | collision.frame) & collision.hitEdge[3]);
		rightSide  = collision.borderRight | ((collision.obstacle | collision.frame) & collision.hitEdge[1]);
		topSide    = collision.borderTop | (collision.obstacle & collision.hitEdge[2]);
		bottomSide = collision.flipper | (collision.obstacle & collision.hitEdge[0]);
		springHit  = collision.springPulse & collision.hitEdge[0];

		if ((leftSide && oldX < 0) || (rightSide && oldX > 0))
			modelSpeedX = -oldX;
		else if (collision.flipper && oldY > 0)
			modelSpeedX = oldX + flipperSpeedX;
		else if (collision.bumperPulse && oldY < 0)
			modelSpeedX = oldY;

		if ((topSide && oldY < 0) || (bottomSide && oldY > 0))
			modelSpeedY = -oldY;
		else if (springHit)
			modelSpeedY = (springSpeedY < 0) ? oldY + springSpeedY : -oldY;
		else if (collision.bumperPulse && oldY < 0)
			modelSpeedY = -oldY;
	endtask

	task automatic compareValue(input string name, input ballPkg::pixelT expected,
			input ballPkg::pixelT actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			restartBall();
			checkPending = 1'b1; // Start position shows during reset
		end
		else begin
			if (levelReset)
				restartBall();
			else if (!pause && frameTick) begin
				modelPosX   = modelPosX + modelSpeedX;
				modelPosY   = modelPosY + modelSpeedY;
				modelSpeedY = modelSpeedY + `GRAVITY;
			end
			else if (!pause)
				applyCollision();
			checkPending = frameTick;
		end
	end

	// Outputs settle at the rising edge, so look half a cycle later
	always @(negedge clk) begin
		if (checkPending) begin
			compareValue("topLeftX", toPixel(modelPosX), topLeftX);
			compareValue("topLeftY", toPixel(modelPosY), topLeftY);
		end
	end

	always @(posedge clk) begin
		if (testEnd) begin
			if (mismatches == mismatchesAtStart)
				$display("Test %0d passed", testNum);
			else begin
				$display("Test %0d failed with %0d mismatches", testNum,
					mismatches - mismatchesAtStart);
				failCount++;
			end
			runCount++;
			mismatchesAtStart = mismatches;
		end
	end

endmodule

// File: sim/ballPhysicsTb.sv
`timescale 1ns/1ps

module ballPhysicsTb;

	localparam int numTests    = 35;
	localparam int fixedTests  = 15;
	localparam int resetCycles = 16;
	localparam int idleCycles  = 3;  // After each frame tick
	localparam int clkPeriod   = 20;

	// Upper byte of the collision struct
	localparam logic [7:0] pulseTop      = 8'h80;
	localparam logic [7:0] pulseLeft     = 8'h40;
	localparam logic [7:0] pulseRight    = 8'h20;
	localparam logic [7:0] pulseFlipper  = 8'h10;
	localparam logic [7:0] pulseObstacle = 8'h08;
	localparam logic [7:0] pulseSpring   = 8'h04;
	localparam logic [7:0] pulseBumper   = 8'h02;
	localparam logic [7:0] pulseFrame    = 8'h01;

	localparam logic [3:0] edgeBottom = 4'h1;
	localparam logic [3:0] edgeRight  = 4'h2;
	localparam logic [3:0] edgeLeft   = 4'h8;

	typedef struct {
		int                 testNum;
		ballPkg::collisionT coll;
		logic               pause;
		logic               levelReset;
		ballPkg::speedT     flipperSpeedX;
		ballPkg::speedT     springSpeedY;
		int                 frames;
	} stimEntryT;

	stimEntryT stimTable [numTests];

	logic               clk = 1'b0;
	logic               resetN;
	logic               frameTick;
	logic               pause;
	logic               levelReset;
	ballPkg::collisionT collision;
	ballPkg::speedT     flipperSpeedX;
	ballPkg::speedT     springSpeedY;
	ballPkg::pixelT     topLeftX;
	ballPkg::pixelT     topLeftY;
	int                 testNum;
	logic               testEnd;
	int                 testsRun;
	int                 testsFailed;
	int                 errorCount;
	logic               tableReady = 1'b0;
	int                 maxFrames = 0;

	always #(clkPeriod / 2) clk = ~clk;

	ballPhysicsTop ballPhysicsTop_inst (
		.clk           (clk),
		.resetN        (resetN),
		.frameTick     (frameTick),
		.pause         (pause),
		.levelReset    (levelReset),
		.collision     (collision),
		.flipperSpeedX (flipperSpeedX),
		.springSpeedY  (springSpeedY),
		.topLeftX      (topLeftX),
		.topLeftY      (topLeftY)
	);

	ballPhysicsChecker ballPhysicsChecker_inst (
		.clk           (clk),
		.resetN        (resetN),
		.frameTick     (frameTick),
		.pause         (pause),
		.levelReset    (levelReset),
		.collision     (collision),
		.flipperSpeedX (flipperSpeedX),
		.springSpeedY  (springSpeedY),
		.topLeftX      (topLeftX),
		.topLeftY      (topLeftY),
		.testNum       (testNum),
		.testEnd       (testEnd),
		.testsRun      (testsRun),
		.testsFailed   (testsFailed),
		.errorCount    (errorCount)
	);

	task automatic addEntry(input int idx, input logic [7:0] pulses, input logic [3:0] edges,
			input logic p, input logic lr, input ballPkg::speedT flip,
			input ballPkg::speedT spring, input int frames);
		stimTable[idx].testNum       = idx + 1;
		stimTable[idx].coll          = {pulses, edges};
		stimTable[idx].pause         = p;
		stimTable[idx].levelReset    = lr;
		stimTable[idx].flipperSpeedX = flip;
		stimTable[idx].springSpeedY  = spring;
		stimTable[idx].frames        = frames;
	endtask

	// Collision for one cycle, then the frame ticks
	task automatic runEntry(input stimEntryT entry);
		@(negedge clk);
		testNum       = entry.testNum;
		pause         = entry.pause;
		levelReset    = entry.levelReset;
		flipperSpeedX = entry.flipperSpeedX;
		springSpeedY  = entry.springSpeedY;
		collision     = entry.coll;
		@(negedge clk);
		collision = '0;
		for (int f = 0; f < entry.frames; f++) begin
			@(negedge clk);
			frameTick = 1'b1;
			@(negedge clk);
			frameTick = 1'b0;
			repeat (idleCycles - 1) @(negedge clk);
		end
		@(negedge clk);
		testEnd = 1'b1;
		@(negedge clk);
		testEnd = 1'b0;
	endtask

	initial begin
		resetN        = 1'b0;
		frameTick     = 1'b0;
		pause         = 1'b0;
		levelReset    = 1'b0;
		collision     = '0;
		flipperSpeedX = '0;
		springSpeedY  = '0;
		testNum       = 0;
		testEnd       = 1'b0;
		void'($urandom(32'h85c0));

		addEntry(0,  8'h00,         4'h0,       0, 0, 0,   0,    8); // Free fall
		addEntry(1,  pulseFlipper,  4'h0,       0, 0, 200, 0,    3);
		addEntry(2,  pulseTop,      4'h0,       0, 0, 0,   0,    2);
		addEntry(3,  pulseLeft,     4'h0,       0, 0, 0,   0,    2); // Against the motion
		addEntry(4,  pulseRight,    4'h0,       0, 0, 0,   0,    2);
		addEntry(5,  pulseObstacle, edgeLeft,   0, 0, 0,   0,    2);
		addEntry(6,  pulseFrame,    edgeRight,  0, 0, 0,   0,    2);
		addEntry(7,  pulseSpring,   edgeBottom, 0, 0, 0,   -400, 3); // Boost upward
		addEntry(8,  pulseBumper,   4'h0,       0, 0, 0,   0,    2);
		addEntry(9,  pulseSpring,   edgeBottom, 0, 0, 0,   50,   2);
		addEntry(10, pulseObstacle, edgeBottom, 0, 0, 0,   0,    2); // Rising, no effect
		addEntry(11, pulseTop,      4'h0,       1, 0, 0,   0,    3); // Paused
		addEntry(12, 8'h00,         4'h0,       0, 0, 0,   0,    2); // Motion as before pause
		addEntry(13, 8'h00,         4'h0,       1, 1, 0,   0,    2);
		addEntry(14, 8'h00,         4'h0,       0, 0, 0,   0,    3);
		for (int i = fixedTests; i < numTests; i++) begin
			addEntry(i, 8'($urandom) & 8'($urandom), 4'($urandom), ($urandom % 8) == 0,
				($urandom % 10) == 0, ballPkg::speedT'($urandom % 256) - 128,
				ballPkg::speedT'($urandom % 512) - 300, 1 + int'($urandom % 3));
		end
		foreach (stimTable[i])
			if (stimTable[i].frames > maxFrames)
				maxFrames = stimTable[i].frames;
		tableReady = 1'b1;

		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;

		foreach (stimTable[i])
			runEntry(stimTable[i]);
		repeat (2) @(negedge clk);

		$display("Tests run: %0d, failed: %0d, mismatches: %0d", testsRun, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0 && testsRun == numTests) begin
			$display("All tests passed!");
		end
		else begin
			if (testsRun != numTests)
				$display("Checker saw %0d tests instead of %0d", testsRun, numTests);
			$display("Test failures found");
		end
		$finish;
	end

	// Twice the worst case of every entry plus reset
	initial begin
		longint limitNs;

		wait (tableReady);
		limitNs = 2 * (longint'(numTests) * (5 + maxFrames * (1 + idleCycles)) + resetCycles)
			* clkPeriod;
		#(limitNs);
		$display("Simulation timed out after %0d ns", limitNs);
		$display("Test failures found");
		$finish;
	end

endmodule
